// ==== hdl/stbuf_cfg.svh ====
`ifndef STBUF_CFG_SVH
`define STBUF_CFG_SVH

// datapath and ROB tag widths
`define STB_XLEN 32
`define STB_ROB_W 4

// store buffer entries, power of two
`define STB_DEPTH 4

// data memory size in words
`define STB_MEM_WORDS 64

// exception causes reported on the CDB
`define STB_EXC_MISALIGN 6
`define STB_EXC_FAULT 7

`endif

// ==== hdl/stbuf_pkg.sv ====
`include "stbuf_cfg.svh"

package stbuf_pkg;

    // -------------------------------------------------------------------------
    // plain vector types
    // -------------------------------------------------------------------------

    typedef logic [`STB_XLEN-1:0]          xlen_t;
    typedef logic [`STB_ROB_W-1:0]         rob_idx_t;
    typedef logic [$clog2(`STB_DEPTH)-1:0] sb_tag_t;
    // 0 byte, 1 halfword, 2 word
    typedef logic [1:0]                    ldst_width_t;
    typedef logic [3:0]                    except_code_t;

    // -------------------------------------------------------------------------
    // bundles
    // -------------------------------------------------------------------------

    // one source operand, value valid when ready is set
    typedef struct packed {
        logic     ready;
        rob_idx_t rob_idx;
        xlen_t    value;
    } op_data_t;

    typedef struct packed {
        rob_idx_t     rob_idx;
        xlen_t        value;
        logic         except_raised;
        except_code_t except_code;
    } cdb_data_t;

    // effective address calculation
    typedef struct packed {
        sb_tag_t     tag;
        xlen_t       base;
        xlen_t       offs;
        ldst_width_t width;
    } adder_req_t;

    typedef struct packed {
        sb_tag_t      tag;
        xlen_t        result;
        logic         except_raised;
        except_code_t except_code;
    } adder_ans_t;

    // memory side payloads
    typedef struct packed {
        logic        is_store;
        ldst_width_t width;
        xlen_t       addr;
        xlen_t       wdata;
    } mem_req_t;

    typedef struct packed {
        xlen_t        rdata;
        logic         except_raised;
        except_code_t except_code;
    } mem_ans_t;

endpackage

// ==== hdl/addr_adder.sv ====
`timescale 1ns/10ps
`include "stbuf_cfg.svh"

module addr_adder (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  stbuf_pkg::adder_req_t req_i,
    output logic                  ans_valid_o,
    output stbuf_pkg::adder_ans_t ans_o
);

    stbuf_pkg::xlen_t sum;
    logic             misaligned;
    logic             busy;

    assign sum = req_i.base + req_i.offs;

    // halfword needs bit 0 clear, word needs bits 1:0 clear
    always_comb begin : p_align
        case (req_i.width)
            2'd1:    misaligned = sum[0];
            2'd2:    misaligned = |sum[1:0];
            default: misaligned = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin : p_busy
        if (!rst_n_i) busy <= 1'b0;
        else          busy <= req_valid_i && req_ready_o;
    end

    always_ff @(posedge clk_i) begin : p_answer
        if (req_valid_i && req_ready_o) begin
            ans_o.tag           <= req_i.tag;
            ans_o.result        <= sum;
            ans_o.except_raised <= misaligned;
            ans_o.except_code   <= misaligned ? stbuf_pkg::except_code_t'(`STB_EXC_MISALIGN) : '0;
        end
    end

    assign req_ready_o = !busy;
    assign ans_valid_o = busy;

endmodule

// ==== hdl/mem_arbiter.sv ====
`timescale 1ns/10ps

module mem_arbiter (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                sb_req_i,
    output logic                sb_ack_o,
    input  stbuf_pkg::mem_req_t sb_data_i,
    output stbuf_pkg::mem_ans_t sb_ans_o,
    input  logic                ld_req_i,
    output logic                ld_ack_o,
    input  stbuf_pkg::mem_req_t ld_data_i,
    output stbuf_pkg::mem_ans_t ld_ans_o,
    output logic                mem_req_o,
    input  logic                mem_ack_i,
    output stbuf_pkg::mem_req_t mem_data_o,
    input  stbuf_pkg::mem_ans_t mem_ans_i
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_SB,
        ARB_LD
    } arb_state_t;

    arb_state_t state;
    logic       last_ld;

    always_ff @(posedge clk_i or negedge rst_n_i) begin : p_arb
        if (!rst_n_i) begin
            state   <= ARB_IDLE;
            last_ld <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    // on a tie the port that lost last time wins
                    if (sb_req_i && (!ld_req_i || last_ld)) begin
                        state   <= ARB_SB;
                        last_ld <= 1'b0;
                    end else if (ld_req_i) begin
                        state   <= ARB_LD;
                        last_ld <= 1'b1;
                    end
                end
                // grant ends once the handshake is back to zero
                ARB_SB:  if (!sb_req_i && !mem_ack_i) state <= ARB_IDLE;
                ARB_LD:  if (!ld_req_i && !mem_ack_i) state <= ARB_IDLE;
                default: state <= ARB_IDLE;
            endcase
        end
    end

    assign mem_req_o  = ((state == ARB_SB) && sb_req_i) || ((state == ARB_LD) && ld_req_i);
    assign mem_data_o = (state == ARB_LD) ? ld_data_i : sb_data_i;
    assign sb_ack_o   = (state == ARB_SB) && mem_ack_i;
    assign ld_ack_o   = (state == ARB_LD) && mem_ack_i;
    assign sb_ans_o   = (state == ARB_SB) ? mem_ans_i : '0;
    assign ld_ans_o   = (state == ARB_LD) ? mem_ans_i : '0;

endmodule

// ==== hdl/data_mem.sv ====
`timescale 1ns/10ps
`include "stbuf_cfg.svh"

module data_mem (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                req_i,
    output logic                ack_o,
    input  stbuf_pkg::mem_req_t data_i,
    output stbuf_pkg::mem_ans_t ans_o
);

    localparam int IDX_W = $clog2(`STB_MEM_WORDS);

    stbuf_pkg::xlen_t mem [`STB_MEM_WORDS];
    stbuf_pkg::xlen_t wdata_lanes;
    logic [3:0]       byte_en;
    logic [IDX_W-1:0] word_idx;
    logic             in_range, fire;

    assign fire     = req_i && !ack_o;
    assign in_range = data_i.addr < stbuf_pkg::xlen_t'(4 * `STB_MEM_WORDS);
    assign word_idx = data_i.addr[IDX_W+1:2];

    // replicate the store data so every lane sees it
    always_comb begin : p_lanes
        case (data_i.width)
            2'd0: begin
                byte_en     = 4'b0001 << data_i.addr[1:0];
                wdata_lanes = {4{data_i.wdata[7:0]}};
            end
            2'd1: begin
                byte_en     = data_i.addr[1] ? 4'b1100 : 4'b0011;
                wdata_lanes = {2{data_i.wdata[15:0]}};
            end
            default: begin
                byte_en     = 4'b1111;
                wdata_lanes = data_i.wdata;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin : p_mem
        if (!rst_n_i) begin
            ack_o <= 1'b0;
            for (int w = 0; w < `STB_MEM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (fire) begin
            ack_o <= 1'b1;
            if (data_i.is_store && in_range) begin
                for (int b = 0; b < 4; b++) begin
                    if (byte_en[b]) mem[word_idx][8*b +: 8] <= wdata_lanes[8*b +: 8];
                end
            end
        end else if (!req_i) begin
            ack_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin : p_answer
        if (fire) begin
            ans_o.rdata         <= in_range ? mem[word_idx] : '0;
            ans_o.except_raised <= !in_range;
            ans_o.except_code   <= in_range ? '0 : stbuf_pkg::except_code_t'(`STB_EXC_FAULT);
        end
    end

endmodule

// ==== hdl/store_buffer.sv ====
`timescale 1ns/10ps
`include "stbuf_cfg.svh"

module store_buffer (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   issue_valid_i,
    output logic                   issue_ready_o,
    input  stbuf_pkg::ldst_width_t issue_width_i,
    input  stbuf_pkg::op_data_t    issue_rs1_i,
    input  stbuf_pkg::op_data_t    issue_rs2_i,
    input  stbuf_pkg::xlen_t       issue_imm_i,
    input  stbuf_pkg::rob_idx_t    issue_rob_idx_i,
    input  logic                   cdb_valid_i,
    input  stbuf_pkg::cdb_data_t   cdb_data_i,
    input  logic                   cdb_ready_i,
    output logic                   cdb_valid_o,
    output stbuf_pkg::cdb_data_t   cdb_data_o,
    output logic                   adder_valid_o,
    input  logic                   adder_ready_i,
    output stbuf_pkg::adder_req_t  adder_req_o,
    input  stbuf_pkg::adder_ans_t  adder_ans_i,
    output logic                   mem_req_o,
    input  logic                   mem_ack_i,
    output stbuf_pkg::mem_req_t    mem_data_o,
    input  stbuf_pkg::mem_ans_t    mem_ans_i
);

    typedef enum logic [2:0] {
        SB_EMPTY,
        SB_OP_PENDING,
        SB_ADDR_PENDING,
        SB_MEM_PENDING,
        SB_MEM_WAIT,
        SB_COMPLETED
    } sb_state_t;

    // rs2 carries the store data, addr holds the offset until the adder answers
    typedef struct packed {
        stbuf_pkg::ldst_width_t  width;
        stbuf_pkg::op_data_t     rs1;
        stbuf_pkg::op_data_t     rs2;
        stbuf_pkg::rob_idx_t     rob_idx;
        stbuf_pkg::xlen_t        addr;
        logic                    except_raised;
        stbuf_pkg::except_code_t except_code;
    } sb_entry_t;

    sb_entry_t            ent [`STB_DEPTH];
    sb_state_t            state [`STB_DEPTH];
    sb_state_t            next_state [`STB_DEPTH];
    stbuf_pkg::sb_tag_t   head_idx, tail_idx, addr_idx;
    logic                 push, pop, addr_fire, ans_pending;
    logic [`STB_DEPTH-1:0] push_e, head_e, rs1_hit, rs2_hit, ans_hit;

    assign push      = issue_valid_i && issue_ready_o;
    assign pop       = cdb_valid_o && cdb_ready_i;
    assign addr_fire = adder_valid_o && adder_ready_i;

    // per-entry wakeup and select
    always_comb begin : p_entry_match
        for (int i = 0; i < `STB_DEPTH; i++) begin
            push_e[i]  = push && (tail_idx == stbuf_pkg::sb_tag_t'(i));
            head_e[i]  = head_idx == stbuf_pkg::sb_tag_t'(i);
            rs1_hit[i] = cdb_valid_i && (state[i] == SB_OP_PENDING) && !ent[i].rs1.ready
                         && (ent[i].rs1.rob_idx == cdb_data_i.rob_idx);
            rs2_hit[i] = cdb_valid_i && (state[i] == SB_OP_PENDING) && !ent[i].rs2.ready
                         && (ent[i].rs2.rob_idx == cdb_data_i.rob_idx);
            ans_hit[i] = ans_pending && (state[i] == SB_ADDR_PENDING)
                         && (adder_ans_i.tag == stbuf_pkg::sb_tag_t'(i));
        end
    end

    // -------------------------------------------------------------------------
    // entry state machines
    // -------------------------------------------------------------------------

    always_comb begin : p_next_state
        for (int i = 0; i < `STB_DEPTH; i++) begin
            next_state[i] = state[i];
            case (state[i])
                SB_EMPTY: begin
                    if (push_e[i]) begin
                        if (issue_rs1_i.ready && issue_rs2_i.ready) begin
                            next_state[i] = SB_ADDR_PENDING;
                        end else begin
                            next_state[i] = SB_OP_PENDING;
                        end
                    end
                end
                SB_OP_PENDING: begin
                    if ((ent[i].rs1.ready || rs1_hit[i]) && (ent[i].rs2.ready || rs2_hit[i])) begin
                        next_state[i] = SB_ADDR_PENDING;
                    end
                end
                SB_ADDR_PENDING: begin
                    // misaligned stores skip memory
                    if (ans_hit[i]) begin
                        next_state[i] = adder_ans_i.except_raised ? SB_COMPLETED : SB_MEM_PENDING;
                    end
                end
                SB_MEM_PENDING: begin
                    if (head_e[i] && mem_ack_i) begin
                        next_state[i] = SB_MEM_WAIT;
                    end
                end
                SB_MEM_WAIT: begin
                    if (!mem_ack_i) begin
                        next_state[i] = SB_COMPLETED;
                    end
                end
                SB_COMPLETED: begin
                    if (pop && head_e[i]) begin
                        next_state[i] = SB_EMPTY;
                    end
                end
                default: next_state[i] = SB_EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin : p_state
        if (!rst_n_i) begin
            for (int i = 0; i < `STB_DEPTH; i++) begin
                state[i] <= SB_EMPTY;
            end
        end else begin
            state <= next_state;
        end
    end

    // entry payload
    always_ff @(posedge clk_i) begin : p_entry_data
        for (int i = 0; i < `STB_DEPTH; i++) begin
            if (push_e[i]) begin
                ent[i].width         <= issue_width_i;
                ent[i].rs1           <= issue_rs1_i;
                ent[i].rs2           <= issue_rs2_i;
                ent[i].rob_idx       <= issue_rob_idx_i;
                ent[i].addr          <= issue_imm_i;
                ent[i].except_raised <= 1'b0;
                ent[i].except_code   <= '0;
            end else begin
                if (rs1_hit[i]) begin
                    ent[i].rs1.ready <= 1'b1;
                    ent[i].rs1.value <= cdb_data_i.value;
                end
                if (rs2_hit[i]) begin
                    ent[i].rs2.ready <= 1'b1;
                    ent[i].rs2.value <= cdb_data_i.value;
                end
                if (ans_hit[i]) begin
                    ent[i].addr          <= adder_ans_i.result;
                    ent[i].except_raised <= adder_ans_i.except_raised;
                    ent[i].except_code   <= adder_ans_i.except_code;
                end
                if ((state[i] == SB_MEM_PENDING) && head_e[i] && mem_ack_i) begin
                    ent[i].except_raised <= mem_ans_i.except_raised;
                    ent[i].except_code   <= mem_ans_i.except_code;
                end
            end
        end
    end

    // -------------------------------------------------------------------------
    // head, tail and address pointers
    // -------------------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_n_i) begin : p_pointers
        if (!rst_n_i) begin
            head_idx    <= '0;
            tail_idx    <= '0;
            addr_idx    <= '0;
            ans_pending <= 1'b0;
        end else begin
            if (push) tail_idx <= tail_idx + stbuf_pkg::sb_tag_t'(1);
            if (pop) head_idx <= head_idx + stbuf_pkg::sb_tag_t'(1);
            if (addr_fire) addr_idx <= addr_idx + stbuf_pkg::sb_tag_t'(1);
            // adder answers exactly one cycle after acceptance
            ans_pending <= addr_fire;
        end
    end

    assign issue_ready_o = state[tail_idx] == SB_EMPTY;

    assign cdb_valid_o                = state[head_idx] == SB_COMPLETED;
    assign cdb_data_o.rob_idx         = ent[head_idx].rob_idx;
    assign cdb_data_o.value           = ent[head_idx].addr;
    assign cdb_data_o.except_raised   = ent[head_idx].except_raised;
    assign cdb_data_o.except_code     = ent[head_idx].except_code;

    // address requests go out in issue order
    assign adder_valid_o     = state[addr_idx] == SB_ADDR_PENDING;
    assign adder_req_o.tag   = addr_idx;
    assign adder_req_o.base  = ent[addr_idx].rs1.value;
    assign adder_req_o.offs  = ent[addr_idx].addr;
    assign adder_req_o.width = ent[addr_idx].width;

    // head store owns the memory request line
    assign mem_req_o           = state[head_idx] == SB_MEM_PENDING;
    assign mem_data_o.is_store = 1'b1;
    assign mem_data_o.width    = ent[head_idx].width;
    assign mem_data_o.addr     = ent[head_idx].addr;
    assign mem_data_o.wdata    = ent[head_idx].rs2.value;

endmodule

// ==== hdl/lsu_top.sv ====
`timescale 1ns/10ps

module lsu_top (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   issue_valid_i,
    output logic                   issue_ready_o,
    input  stbuf_pkg::ldst_width_t issue_width_i,
    input  stbuf_pkg::op_data_t    issue_rs1_i,
    input  stbuf_pkg::op_data_t    issue_rs2_i,
    input  stbuf_pkg::xlen_t       issue_imm_i,
    input  stbuf_pkg::rob_idx_t    issue_rob_idx_i,
    input  logic                   cdb_valid_i,
    input  stbuf_pkg::cdb_data_t   cdb_data_i,
    input  logic                   cdb_ready_i,
    output logic                   cdb_valid_o,
    output stbuf_pkg::cdb_data_t   cdb_data_o,
    input  logic                   ld_req_i,
    input  stbuf_pkg::xlen_t       ld_addr_i,
    output logic                   ld_ack_o,
    output stbuf_pkg::xlen_t       ld_data_o,
    output logic                   ld_err_o
);

    logic                  adder_valid, adder_ready;
    stbuf_pkg::adder_req_t adder_req;
    stbuf_pkg::adder_ans_t adder_ans;
    logic                  sb_mem_req, sb_mem_ack, mem_req, mem_ack;
    stbuf_pkg::mem_req_t   sb_mem_data, ld_mem_data, mem_data;
    stbuf_pkg::mem_ans_t   sb_mem_ans, ld_mem_ans, mem_ans;

    // loads always read a whole word
    assign ld_mem_data = '{is_store: 1'b0, width: 2'd2, addr: ld_addr_i, wdata: '0};
    assign ld_data_o   = ld_mem_ans.rdata;
    assign ld_err_o    = ld_mem_ans.except_raised;

    store_buffer u_store_buffer (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .issue_valid_i   (issue_valid_i),
        .issue_ready_o   (issue_ready_o),
        .issue_width_i   (issue_width_i),
        .issue_rs1_i     (issue_rs1_i),
        .issue_rs2_i     (issue_rs2_i),
        .issue_imm_i     (issue_imm_i),
        .issue_rob_idx_i (issue_rob_idx_i),
        .cdb_valid_i     (cdb_valid_i),
        .cdb_data_i      (cdb_data_i),
        .cdb_ready_i     (cdb_ready_i),
        .cdb_valid_o     (cdb_valid_o),
        .cdb_data_o      (cdb_data_o),
        .adder_valid_o   (adder_valid),
        .adder_ready_i   (adder_ready),
        .adder_req_o     (adder_req),
        .adder_ans_i     (adder_ans),
        .mem_req_o       (sb_mem_req),
        .mem_ack_i       (sb_mem_ack),
        .mem_data_o      (sb_mem_data),
        .mem_ans_i       (sb_mem_ans)
    );

    // the buffer times the answer itself
    addr_adder u_addr_adder (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (adder_valid),
        .req_ready_o (adder_ready),
        .req_i       (adder_req),
        .ans_valid_o (),
        .ans_o       (adder_ans)
    );

    mem_arbiter u_mem_arbiter (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .sb_req_i   (sb_mem_req),
        .sb_ack_o   (sb_mem_ack),
        .sb_data_i  (sb_mem_data),
        .sb_ans_o   (sb_mem_ans),
        .ld_req_i   (ld_req_i),
        .ld_ack_o   (ld_ack_o),
        .ld_data_i  (ld_mem_data),
        .ld_ans_o   (ld_mem_ans),
        .mem_req_o  (mem_req),
        .mem_ack_i  (mem_ack),
        .mem_data_o (mem_data),
        .mem_ans_i  (mem_ans)
    );

    data_mem u_data_mem (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (mem_req),
        .ack_o   (mem_ack),
        .data_i  (mem_data),
        .ans_o   (mem_ans)
    );

endmodule

// ==== testbench/tb_lsu.sv ====
`timescale 1ns/10ps

module tb_lsu;

    localparam int MAX_OPS       = 64;
    localparam int OP_FIELDS     = 12;
    localparam int CYCLES_PER_OP = 200;

    logic                   clk_i;
    logic                   rst_n_i;
    logic                   issue_valid_i;
    logic                   issue_ready_o;
    stbuf_pkg::ldst_width_t issue_width_i;
    stbuf_pkg::op_data_t    issue_rs1_i;
    stbuf_pkg::op_data_t    issue_rs2_i;
    stbuf_pkg::xlen_t       issue_imm_i;
    stbuf_pkg::rob_idx_t    issue_rob_idx_i;
    logic                   cdb_valid_i;
    stbuf_pkg::cdb_data_t   cdb_data_i;
    logic                   cdb_ready_i;
    logic                   cdb_valid_o;
    stbuf_pkg::cdb_data_t   cdb_data_o;
    logic                   ld_req_i;
    stbuf_pkg::xlen_t       ld_addr_i;
    logic                   ld_ack_o;
    stbuf_pkg::xlen_t       ld_data_o;
    logic                   ld_err_o;

    // test table, one row per line of the test file
    string       op_kind [MAX_OPS];
    string       op_name [MAX_OPS];
    logic [31:0] op_fld  [MAX_OPS][OP_FIELDS];
    int          n_ops;
    logic        ops_loaded;
    int          n_pass;
    int          n_fail;

    // completions still owed by the store buffer, oldest first
    string                exp_name [$];
    stbuf_pkg::cdb_data_t exp_cdb  [$];
    logic                 held_valid;
    stbuf_pkg::cdb_data_t held_data;

    lsu_top dut (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .issue_valid_i   (issue_valid_i),
        .issue_ready_o   (issue_ready_o),
        .issue_width_i   (issue_width_i),
        .issue_rs1_i     (issue_rs1_i),
        .issue_rs2_i     (issue_rs2_i),
        .issue_imm_i     (issue_imm_i),
        .issue_rob_idx_i (issue_rob_idx_i),
        .cdb_valid_i     (cdb_valid_i),
        .cdb_data_i      (cdb_data_i),
        .cdb_ready_i     (cdb_ready_i),
        .cdb_valid_o     (cdb_valid_o),
        .cdb_data_o      (cdb_data_o),
        .ld_req_i        (ld_req_i),
        .ld_addr_i       (ld_addr_i),
        .ld_ack_o        (ld_ack_o),
        .ld_data_o       (ld_data_o),
        .ld_err_o        (ld_err_o)
    );

    always #10 clk_i = ~clk_i;

    // -------------------------------------------------------------------------
    // compare tasks
    // -------------------------------------------------------------------------

    task automatic check_cdb(input string name, input stbuf_pkg::cdb_data_t exp,
                             input stbuf_pkg::cdb_data_t act);
        if (act !== exp) begin
            n_fail++;
            $display("error %s expected rob=%h value=%h exc=%b code=%h", name,
                     exp.rob_idx, exp.value, exp.except_raised, exp.except_code,
                     " actual rob=%h value=%h exc=%b code=%h",
                     act.rob_idx, act.value, act.except_raised, act.except_code);
        end else begin
            n_pass++;
            $display("ok    %s", name);
        end
    endtask

    task automatic check_word(input string name, input stbuf_pkg::xlen_t exp,
                              input stbuf_pkg::xlen_t act);
        if (act !== exp) begin
            n_fail++;
            $display("error %s expected %h actual %h", name, exp, act);
        end else begin
            n_pass++;
            $display("ok    %s", name);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            n_fail++;
            $display("error %s expected %b actual %b", name, exp, act);
        end else begin
            n_pass++;
            $display("ok    %s", name);
        end
    endtask

    // -------------------------------------------------------------------------
    // test file
    // -------------------------------------------------------------------------

    function automatic int field_count(input string kind);
        case (kind)
            "store":     return 12;
            "broadcast": return 2;
            "load":      return 3;
            "stall":     return 2;
            default:     return -1;
        endcase
    endfunction

    task automatic read_tests();
        int               fd;
        int               nf;
        int               got;
        string            kind;
        logic [8*128-1:0] rest;
        n_ops = 0;
        fd = $fopen("testbench/lsu_tests.txt", "r");
        if (fd == 0) begin
            n_fail++;
            $display("could not open testbench/lsu_tests.txt");
        end else begin
            while (n_ops < MAX_OPS && $fscanf(fd, "%s", kind) == 1) begin
                if (kind.substr(0, 0) == "#") begin
                    void'($fgets(rest, fd));
                end else begin
                    nf  = field_count(kind);
                    got = $fscanf(fd, "%s", op_name[n_ops]);
                    for (int f = 0; f < nf; f++) begin
                        got += $fscanf(fd, "%h", op_fld[n_ops][f]);
                    end
                    if (nf < 0 || got != nf + 1) begin
                        n_fail++;
                        $display("bad line in the test file near %s %s", kind, op_name[n_ops]);
                    end else begin
                        op_kind[n_ops] = kind;
                        n_ops++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // -------------------------------------------------------------------------
    // operations, each starts and ends on a falling edge
    // -------------------------------------------------------------------------

    task automatic issue_store(input int k);
        stbuf_pkg::cdb_data_t exp;
        exp.rob_idx       = stbuf_pkg::rob_idx_t'(op_fld[k][0]);
        exp.value         = op_fld[k][11];
        exp.except_raised = op_fld[k][9][0];
        exp.except_code   = stbuf_pkg::except_code_t'(op_fld[k][10]);
        while (!issue_ready_o) @(negedge clk_i);
        exp_name.push_back(op_name[k]);
        exp_cdb.push_back(exp);
        issue_rob_idx_i     = stbuf_pkg::rob_idx_t'(op_fld[k][0]);
        issue_width_i       = stbuf_pkg::ldst_width_t'(op_fld[k][1]);
        issue_rs1_i.ready   = op_fld[k][2][0];
        issue_rs1_i.rob_idx = stbuf_pkg::rob_idx_t'(op_fld[k][3]);
        issue_rs1_i.value   = op_fld[k][4];
        issue_rs2_i.ready   = op_fld[k][5][0];
        issue_rs2_i.rob_idx = stbuf_pkg::rob_idx_t'(op_fld[k][6]);
        issue_rs2_i.value   = op_fld[k][7];
        issue_imm_i         = op_fld[k][8];
        issue_valid_i       = 1'b1;
        @(negedge clk_i);
        issue_valid_i = 1'b0;
    endtask

    task automatic send_broadcast(input int k);
        cdb_data_i.rob_idx       = stbuf_pkg::rob_idx_t'(op_fld[k][0]);
        cdb_data_i.value         = op_fld[k][1];
        cdb_data_i.except_raised = 1'b0;
        cdb_data_i.except_code   = '0;
        cdb_valid_i              = 1'b1;
        @(negedge clk_i);
        cdb_valid_i = 1'b0;
    endtask

    // four-phase read on the load port, after all earlier stores are done
    task automatic run_load(input int k);
        stbuf_pkg::xlen_t data;
        logic             err;
        while (exp_cdb.size() != 0) @(negedge clk_i);
        ld_addr_i = op_fld[k][0];
        ld_req_i  = 1'b1;
        while (!ld_ack_o) @(negedge clk_i);
        data     = ld_data_o;
        err      = ld_err_o;
        ld_req_i = 1'b0;
        while (ld_ack_o) @(negedge clk_i);
        check_word(op_name[k], op_fld[k][2], data);
        check_flag({op_name[k], "_err"}, op_fld[k][1][0], err);
    endtask

    // a release first lets the stalled head sit on the cdb output for a while
    task automatic set_stall(input int k);
        if (!op_fld[k][0][0] && !cdb_ready_i) begin
            while (!cdb_valid_o) @(negedge clk_i);
            repeat (4) @(negedge clk_i);
        end
        check_flag(op_name[k], op_fld[k][1][0], issue_ready_o);
        cdb_ready_i = !op_fld[k][0][0];
    endtask

    task automatic run_op(input int k);
        case (op_kind[k])
            "store":     issue_store(k);
            "broadcast": send_broadcast(k);
            "load":      run_load(k);
            "stall":     set_stall(k);
            default:     ;
        endcase
    endtask

    // -------------------------------------------------------------------------
    // processes
    // -------------------------------------------------------------------------

    initial begin : p_main
        clk_i           = 1'b0;
        rst_n_i         = 1'b0;
        issue_valid_i   = 1'b0;
        issue_width_i   = '0;
        issue_rs1_i     = '0;
        issue_rs2_i     = '0;
        issue_imm_i     = '0;
        issue_rob_idx_i = '0;
        cdb_valid_i     = 1'b0;
        cdb_data_i      = '0;
        cdb_ready_i     = 1'b1;
        ld_req_i        = 1'b0;
        ld_addr_i       = '0;
        n_pass          = 0;
        n_fail          = 0;
        held_valid      = 1'b0;
        held_data       = '0;
        ops_loaded      = 1'b0;
        read_tests();
        ops_loaded = 1'b1;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        check_flag("reset_issue_ready", 1'b1, issue_ready_o);
        check_flag("reset_cdb_idle", 1'b0, cdb_valid_o);
        check_flag("reset_load_idle", 1'b0, ld_ack_o);
        for (int i = 0; i < n_ops; i++) begin
            run_op(i);
        end
        while (exp_cdb.size() != 0) @(negedge clk_i);
        $display("checks passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // completions are popped at the next rising edge when ready is high
    initial begin : p_cdb_monitor
        forever begin
            @(negedge clk_i);
            #1;
            if (held_valid && (!cdb_valid_o || cdb_data_o !== held_data)) begin
                n_fail++;
                $display("cdb output changed while cdb_ready_i was low");
            end
            if (cdb_valid_o && cdb_ready_i) begin
                held_valid = 1'b0;
                if (exp_cdb.size() == 0) begin
                    n_fail++;
                    $display("unexpected completion on the cdb output, rob %h",
                             cdb_data_o.rob_idx);
                end else begin
                    check_cdb(exp_name.pop_front(), exp_cdb.pop_front(), cdb_data_o);
                end
            end else begin
                held_valid = cdb_valid_o;
                held_data  = cdb_data_o;
            end
        end
    end

    initial begin : p_watchdog
        wait (ops_loaded === 1'b1);
        repeat ((n_ops + 1) * CYCLES_PER_OP) @(posedge clk_i);
        $display("timeout, the store path stopped responding after %0d cycles",
                 (n_ops + 1) * CYCLES_PER_OP);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== testbench/lsu_tests.txt ====
# store name rob width rs1_rdy rs1_tag rs1_val rs2_rdy rs2_tag rs2_val imm exp_exc exp_code exp_addr
# broadcast name tag value, load name addr exp_err exp_data, stall name hold exp_issue_ready
store st_byte_lane1   1 0 1 0 00000010 1 0 aabbccdd 00000001 0 0 00000011
store st_half_upper   2 1 1 0 00000020 1 0 12345678 00000002 0 0 00000022
store st_word         3 2 1 0 00000030 1 0 cafef00d 00000004 0 0 00000034
store st_byte_lane3   4 0 1 0 00000010 1 0 000000ee 00000003 0 0 00000013
load ld_bytes         00000010 0 ee00dd00
load ld_half          00000020 0 56780000
load ld_word          00000034 0 cafef00d
store st_wait_rs2     5 2 1 0 00000040 0 9 00000000 00000008 0 0 00000048
store st_wait_rs1     6 1 0 b 00000000 1 0 0000beef 00000006 0 0 00000046
broadcast bc_other_a  a 11111111
broadcast bc_other_c  c 00000080
broadcast bc_rs2      9 600dcafe
broadcast bc_rs1      b 00000040
store st_wait_both    7 0 0 d 00000000 0 e 00000000 00000002 0 0 00000052
broadcast bc_both_rs2 e 000000a5
broadcast bc_both_rs1 d 00000050
load ld_wait_rs2      00000048 0 600dcafe
load ld_wait_rs1      00000044 0 beef0000
load ld_wait_both     00000050 0 00a50000
store st_misalign_w   8 2 1 0 00000060 1 0 ffffffff 00000002 1 6 00000062
store st_misalign_h   9 1 1 0 00000064 1 0 ffffffff 00000001 1 6 00000065
load ld_misalign_w    00000060 0 00000000
load ld_misalign_h    00000064 0 00000000
store st_fault        a 2 1 0 00000100 1 0 deadbeef 00000000 1 7 00000100
load ld_fault         00000100 1 00000000
load ld_word0         00000000 0 00000000
stall stall_on        1 1
store st_fill0        b 2 1 0 00000070 1 0 11110000 00000000 0 0 00000070
store st_fill1        c 2 1 0 00000070 1 0 22220001 00000004 0 0 00000074
store st_fill2        d 1 1 0 00000070 1 0 00003333 0000000a 0 0 0000007a
store st_fill3        e 0 1 0 00000070 1 0 00000044 0000000f 0 0 0000007f
stall stall_full_off  0 0
load ld_fill0         00000070 0 11110000
load ld_fill1         00000074 0 22220001
load ld_fill2         00000078 0 33330000
load ld_fill3         0000007c 0 44000000

// ==== verilog.f ====
+incdir+hdl
hdl/stbuf_pkg.sv
hdl/addr_adder.sv
hdl/mem_arbiter.sv
hdl/data_mem.sv
hdl/store_buffer.sv
hdl/lsu_top.sv
testbench/tb_lsu.sv

// ==== Makefile ====
TOP := tb_lsu

.PHONY: all build lint clean

all: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

build:
	verilator --binary --timing -j 0 -f verilog.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -f verilog.f --top-module lsu_top

clean:
	rm -rf obj_dir
